/* files.f */
+incdir+common
common/rv_isa_pkg.sv
common/ex_ctrl_pkg.sv
execute/ex_alu.sv
execute/ex_decoder.sv
execute/ex_operand_stage.sv
execute/ex_branch_unit.sv
hdl/ex_unit_top.sv
tests/ex_unit_chk.sv
tests/ex_unit_tb.sv

/* tests/ex_unit_tb.sv */
// Testbench for the execute-stage top, runs a table of instructions through it and checks every output
`include "ex_macros.svh"
`default_nettype none

module ex_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 50;       // Longest wait for any handshake
    localparam logic [6:0] OP_REG   = 7'h33;
    localparam logic [6:0] OP_IMM   = 7'h13;
    localparam logic [6:0] OP_LUI   = 7'h37;
    localparam logic [6:0] OP_AUIPC = 7'h17;
    localparam logic [6:0] OP_JALR  = 7'h67;
    localparam logic [6:0] OP_LOAD  = 7'h03;

    // One stimulus row with its expected outcome
    typedef struct {
        logic [31:0]           instr;
        logic [`EX_XLEN-1:0]   pc;
        logic [`EX_XLEN-1:0]   rs1;
        logic [`EX_XLEN-1:0]   rs2;
        logic [`EX_REG_AW-1:0] rd;
        bit                    wr;      // Expected out_reg_write
        bit                    chk;     // Result is meaningful and gets compared
        logic [`EX_XLEN-1:0]   res;
        logic [`EX_XLEN-1:0]   npc;
        bit                    tk;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic                  in_ready;
    logic [31:0]           in_instr;
    logic [`EX_XLEN-1:0]   in_pc;
    logic [`EX_XLEN-1:0]   in_rs1_value;
    logic [`EX_XLEN-1:0]   in_rs2_value;
    logic                  out_valid;
    logic                  out_ready;
    logic [`EX_REG_AW-1:0] out_rd;
    logic                  out_reg_write;
    logic [`EX_XLEN-1:0]   out_result;
    logic [`EX_XLEN-1:0]   out_next_pc;
    logic                  out_branch_taken;

    row_t        rows[$];
    int          accept_q[$];              // Cycle of each input transfer, oldest first
    int          cycle = 0;
    int          value_errors = 0;
    int          proto_errors = 0;
    bit          abort = 1'b0;             // Set on the first timeout so both sides stop
    bit          rand_ready = 1'b0;
    integer      seed = 32'ha6b0_2f9c;
    logic [31:0] rnd;

    ex_unit_top ex_unit_top_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    // Consumer side, steady high or a fresh random bit each edge
    initial
    begin
        out_ready = 1'b1;
        forever
        begin
            @(posedge clk);
            rnd = $random(seed);
            out_ready <= rand_ready ? rnd[0] : 1'b1;
        end
    end

    // Instruction encoders with rs1 = x1 and rs2 = x2, the values come from the row
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic add_row(input logic [31:0] instr, input logic [`EX_XLEN-1:0] pc,
                           input logic [`EX_XLEN-1:0] rs1, input logic [`EX_XLEN-1:0] rs2,
                           input logic [`EX_REG_AW-1:0] rd, input bit wr, input bit chk,
                           input logic [`EX_XLEN-1:0] res, input logic [`EX_XLEN-1:0] npc,
                           input bit tk);
        rows.push_back('{instr, pc, rs1, rs2, rd, wr, chk, res, npc, tk});
    endtask

    // Expected values worked out by hand from the RV32I rules
    task automatic build_table();
        add_row(r_type(7'h00, 3'd0, 5'd3, OP_REG), 'h100, 'h5, 'h7, 5'd3, 1, 1, 'hc, 'h104, 0);
        add_row(r_type(7'h20, 3'd0, 5'd4, OP_REG), 'h104, 'h5, 'h7, 5'd4, 1, 1, 'hffff_fffe,
                'h108, 0);
        add_row(r_type(7'h00, 3'd2, 5'd5, OP_REG), 'h108, 'hffff_ffff, 'h1, 5'd5, 1, 1, 'h1,
                'h10c, 0);                                          // -1 < 1 signed
        add_row(r_type(7'h00, 3'd3, 5'd6, OP_REG), 'h10c, 'hffff_ffff, 'h1, 5'd6, 1, 1, 'h0,
                'h110, 0);                                          // Huge unsigned
        add_row(r_type(7'h00, 3'd1, 5'd7, OP_REG), 'h110, 'h3, 'h24, 5'd7, 1, 1, 'h30, 'h114, 0);
        add_row(r_type(7'h00, 3'd5, 5'd8, OP_REG), 'h114, 'h8000_0000, 'h4, 5'd8, 1, 1,
                'h0800_0000, 'h118, 0);
        add_row(r_type(7'h20, 3'd5, 5'd9, OP_REG), 'h118, 'h8000_0000, 'h4, 5'd9, 1, 1,
                'hf800_0000, 'h11c, 0);
        add_row(r_type(7'h00, 3'd4, 5'd10, OP_REG), 'h11c, 'hf0f0_f0f0, 'hff00_ff00, 5'd10, 1, 1,
                'h0ff0_0ff0, 'h120, 0);
        add_row(r_type(7'h00, 3'd6, 5'd11, OP_REG), 'h120, 'hf0f0_f0f0, 'hff00_ff00, 5'd11, 1, 1,
                'hfff0_fff0, 'h124, 0);
        add_row(r_type(7'h00, 3'd7, 5'd12, OP_REG), 'h124, 'hf0f0_f0f0, 'hff00_ff00, 5'd12, 1, 1,
                'hf000_f000, 'h128, 0);
        add_row(i_type(12'hfff, 3'd0, 5'd13, OP_IMM), 'h128, 'h10, 'h0, 5'd13, 1, 1, 'hf,
                'h12c, 0);
        add_row(i_type(12'hfff, 3'd2, 5'd14, OP_IMM), 'h12c, 'hffff_fffe, 'h0, 5'd14, 1, 1, 'h1,
                'h130, 0);
        add_row(i_type(12'hfff, 3'd3, 5'd15, OP_IMM), 'h130, 'h5, 'h0, 5'd15, 1, 1, 'h1,
                'h134, 0);
        add_row(i_type(12'h408, 3'd5, 5'd16, OP_IMM), 'h134, 'hf000_0000, 'h0, 5'd16, 1, 1,
                'hfff0_0000, 'h138, 0);                             // SRAI by 8
        add_row(u_type(20'h12345, 5'd19, OP_LUI), 'h138, 'h0, 'h0, 5'd19, 1, 1, 'h1234_5000,
                'h13c, 0);
        add_row(u_type(20'h00001, 5'd20, OP_AUIPC), 'h2000, 'h0, 'h0, 5'd20, 1, 1, 'h3000,
                'h2004, 0);
        add_row(j_type(21'h1f_fff0, 5'd1), 'h300, 'h0, 'h0, 5'd1, 1, 1, 'h304, 'h2f0, 1);
        add_row(i_type(12'h006, 3'd0, 5'd5, OP_JALR), 'h400, 'h1001, 'h0, 5'd5, 1, 1, 'h404,
                'h1006, 1);                                         // Target bit 0 dropped
        add_row(b_type(13'h0020, 3'd0), 'h500, 'h7, 'h7, 5'd0, 0, 0, 'h0, 'h520, 1);
        add_row(b_type(13'h0020, 3'd1), 'h504, 'h7, 'h7, 5'd0, 0, 0, 'h0, 'h508, 0);
        add_row(b_type(13'h1ffc, 3'd4), 'h600, 'hffff_ffff, 'h1, 5'd0, 0, 0, 'h0, 'h5fc, 1);
        add_row(b_type(13'h1ffc, 3'd5), 'h604, 'hffff_ffff, 'h1, 5'd0, 0, 0, 'h0, 'h608, 0);
        add_row(b_type(13'h0040, 3'd6), 'h608, 'hffff_ffff, 'h1, 5'd0, 0, 0, 'h0, 'h60c, 0);
        add_row(b_type(13'h0100, 3'd7), 'h60c, 'hffff_ffff, 'h1, 5'd0, 0, 0, 'h0, 'h70c, 1);
        add_row(r_type(7'h00, 3'd0, 5'd0, OP_REG), 'h700, 'h1, 'h2, 5'd0, 0, 0, 'h0, 'h704, 0);
        add_row(r_type(7'h00, 3'd0, 5'd3, 7'h7f), 'h704, 'h1, 'h2, 5'd0, 0, 0, 'h0, 'h708, 0);
        add_row(i_type(12'hff8, 3'd2, 5'd6, OP_LOAD), 'h708, 'h1000, 'h0, 5'd6, 1, 1, 'hff8,
                'h70c, 0);
        add_row(s_type(12'h010, 3'd2), 'h70c, 'h2000, 'h55, 5'd0, 0, 1, 'h2010, 'h710, 0);
    endtask

    task automatic check_result(input string name, input logic [`EX_XLEN-1:0] got,
                                input logic [`EX_XLEN-1:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_next_pc(input string name, input logic [`EX_XLEN-1:0] got,
                                 input logic [`EX_XLEN-1:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_rd(input string name, input logic [`EX_REG_AW-1:0] got,
                            input logic [`EX_REG_AW-1:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s got 0x%01h expected 0x%01h", name, got, exp);
            value_errors++;
        end
    endtask

    // Offers each row until the DUT takes it
    task automatic feed_rows();
        int waited;
        bit accepted;
        @(posedge clk);
        foreach (rows[i])
        begin
            in_valid     <= 1'b1;
            in_instr     <= rows[i].instr;
            in_pc        <= rows[i].pc;
            in_rs1_value <= rows[i].rs1;
            in_rs2_value <= rows[i].rs2;
            accepted = 1'b0;
            waited   = 0;
            while (!accepted && waited < TIMEOUT_CYCLES && !abort)
            begin
                @(posedge clk);
                accepted = in_ready;    // in_valid has been high since the previous edge
                waited++;
            end
            if (!accepted)
            begin
                if (!abort)
                begin
                    $display("Timeout: row %0d was never accepted at the input", i);
                    proto_errors++;
                    abort = 1'b1;
                end
                in_valid <= 1'b0;
                return;
            end
            accept_q.push_back(cycle);
        end
        in_valid <= 1'b0;
    endtask

    // Takes outputs in order and compares them with the table
    task automatic collect_rows(input bit timed);
        int waited;
        int accepted_at;
        bit seen;
        foreach (rows[i])
        begin
            seen   = 1'b0;
            waited = 0;
            while (!seen && waited < TIMEOUT_CYCLES && !abort)
            begin
                @(posedge clk);
                seen = out_valid && out_ready;
                waited++;
            end
            if (!seen)
            begin
                if (!abort)
                begin
                    $display("Timeout: no output arrived for row %0d", i);
                    proto_errors++;
                    abort = 1'b1;
                end
                return;
            end
            if (accept_q.size() == 0)
            begin
                $display("Output for row %0d came out with no input accepted for it", i);
                proto_errors++;
            end
            else
            begin
                accepted_at = accept_q.pop_front();
                if (timed && cycle - accepted_at != 2)
                begin
                    $display("Row %0d took %0d cycles instead of 2", i, cycle - accepted_at);
                    proto_errors++;
                end
            end
            check_flag($sformatf("out_reg_write row %0d", i), out_reg_write, rows[i].wr);
            if (rows[i].wr)
                check_rd($sformatf("out_rd row %0d", i), out_rd, rows[i].rd);
            if (rows[i].chk)
                check_result($sformatf("out_result row %0d", i), out_result, rows[i].res);
            check_next_pc($sformatf("out_next_pc row %0d", i), out_next_pc, rows[i].npc);
            check_flag($sformatf("out_branch_taken row %0d", i), out_branch_taken, rows[i].tk);
        end
    endtask

    initial
    begin
        int extra;
        int assert_fails;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_instr     = '0;
        in_pc        = '0;
        in_rs1_value = '0;
        in_rs2_value = '0;
        extra        = 0;
        build_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // First pass with the consumer always ready, so latency is fixed
        fork
            feed_rows();
            collect_rows(1'b1);
        join

        // Second pass under random back-pressure
        if (!abort)
        begin
            @(negedge clk);
            rand_ready = 1'b1;
            fork
                feed_rows();
                collect_rows(1'b0);
            join
            @(negedge clk);
            rand_ready = 1'b0;
            repeat (4)
            begin
                @(posedge clk);
                if (out_valid && out_ready)
                    extra++;
            end
            if (extra != 0 || accept_q.size() != 0)
            begin
                $display("Outputs left over after the table: %0d extra, %0d unmatched inputs",
                         extra, accept_q.size());
                proto_errors++;
            end
        end

        assert_fails = ex_unit_top_inst.ex_unit_chk_inst.fail_count;
        $display("Errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, proto_errors, assert_fails);
        if (value_errors == 0 && proto_errors == 0 && assert_fails == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/ex_unit_chk.sv */
// Assertion checker bound into the execute-stage top, watching reset and the output handshake
`include "ex_macros.svh"
`default_nettype none

module ex_unit_chk (
    input logic                   clk,
    input logic                   rst,
    input logic                   in_ready,
    input logic                   out_valid,
    input logic                   out_ready,
    input logic [`EX_REG_AW-1:0]  out_rd,
    input logic                   out_reg_write,
    input logic [`EX_XLEN-1:0]    out_result,
    input logic [`EX_XLEN-1:0]    out_next_pc,
    input logic                   out_branch_taken
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;    // Read by the testbench at the end of the run

    // Nothing leaves the unit while reset is held
    out_idle_in_reset: assert property (@(posedge clk) rst |-> !out_valid)
        else
        begin
            $error("out_valid is high during reset");
            fail_count++;
        end

    // A stalled output word keeps every field until it is taken
    out_held_on_stall: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_rd) && $stable(out_reg_write)
            && $stable(out_result) && $stable(out_next_pc) && $stable(out_branch_taken))
        else
        begin
            $error("Output changed while out_valid was high and out_ready low");
            fail_count++;
        end

    // Both stages are empty right after reset
    ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> in_ready)
        else
        begin
            $error("in_ready is low one cycle after reset");
            fail_count++;
        end

endmodule

bind ex_unit_top ex_unit_chk ex_unit_chk_inst (.*);

`default_nettype wire

/* hdl/ex_unit_top.sv */
// Execute-stage top, two valid/ready pipeline stages from instruction in to write-back and next PC out
`include "ex_macros.svh"
`default_nettype none

module ex_unit_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [31:0]            in_instr,
    input  logic [`EX_XLEN-1:0]    in_pc,
    input  logic [`EX_XLEN-1:0]    in_rs1_value,
    input  logic [`EX_XLEN-1:0]    in_rs2_value,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`EX_REG_AW-1:0]  out_rd,
    output logic                   out_reg_write,
    output logic [`EX_XLEN-1:0]    out_result,
    output logic [`EX_XLEN-1:0]    out_next_pc,
    output logic                   out_branch_taken
);
    import ex_ctrl_pkg::*;

    // Decoder to stage 1
    alu_op_e               dec_alu_op;
    op_a_src_e             dec_a_src;
    op_b_src_e             dec_b_src;
    ex_kind_e              dec_kind;
    logic [2:0]            dec_funct3;
    logic [`EX_REG_AW-1:0] dec_rd;
    logic                  dec_reg_write;
    logic [`EX_XLEN-1:0]   dec_imm;
    // Stage 1 held values
    logic                  s1_valid;
    logic                  s1_ready;
    ex_kind_e              s1_kind;
    logic [2:0]            s1_funct3;
    logic [`EX_REG_AW-1:0] s1_rd;
    logic                  s1_reg_write;
    logic [`EX_XLEN-1:0]   s1_pc;
    logic [`EX_XLEN-1:0]   s1_imm;
    logic [`EX_XLEN-1:0]   s1_rs1_value;
    logic [`EX_XLEN-1:0]   s1_rs2_value;
    logic [`EX_XLEN-1:0]   alu_result;
    // Branch unit
    logic [`EX_XLEN-1:0]   next_pc;
    logic                  branch_taken;
    logic [`EX_XLEN-1:0]   link;
    logic                  is_jump;

    ex_decoder ex_decoder_inst (
        .instr     (in_instr),
        .alu_op    (dec_alu_op),
        .a_src     (dec_a_src),
        .b_src     (dec_b_src),
        .kind      (dec_kind),
        .funct3    (dec_funct3),
        .rd        (dec_rd),
        .reg_write (dec_reg_write),
        .imm       (dec_imm)
    );

    ex_operand_stage ex_operand_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .alu_op       (dec_alu_op),
        .a_src        (dec_a_src),
        .b_src        (dec_b_src),
        .kind         (dec_kind),
        .funct3       (dec_funct3),
        .rd           (dec_rd),
        .reg_write    (dec_reg_write),
        .imm          (dec_imm),
        .pc           (in_pc),
        .rs1_value    (in_rs1_value),
        .rs2_value    (in_rs2_value),
        .s1_valid     (s1_valid),
        .s1_ready     (s1_ready),
        .s1_kind      (s1_kind),
        .s1_funct3    (s1_funct3),
        .s1_rd        (s1_rd),
        .s1_reg_write (s1_reg_write),
        .s1_pc        (s1_pc),
        .s1_imm       (s1_imm),
        .s1_rs1_value (s1_rs1_value),
        .s1_rs2_value (s1_rs2_value),
        .alu_result   (alu_result)
    );

    ex_branch_unit ex_branch_unit_inst (
        .kind         (s1_kind),
        .funct3       (s1_funct3),
        .pc           (s1_pc),
        .rs1_value    (s1_rs1_value),
        .rs2_value    (s1_rs2_value),
        .imm          (s1_imm),
        .next_pc      (next_pc),
        .branch_taken (branch_taken),
        .link         (link)
    );

    assign is_jump  = (s1_kind == KIND_JAL) || (s1_kind == KIND_JALR);
    // Stage 2 takes a word when empty or when the consumer drains it this cycle
    assign s1_ready = !out_valid || out_ready;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            out_valid <= 1'b0;
        else if (s1_ready)
            out_valid <= s1_valid;
    end

    // Output payload holds still under back-pressure
    always_ff @(posedge clk)
    begin
        if (s1_valid && s1_ready)
        begin
            out_rd           <= s1_rd;
            out_reg_write    <= s1_reg_write;
            out_result       <= is_jump ? link : alu_result;   // Jumps write pc+4
            out_next_pc      <= next_pc;
            out_branch_taken <= branch_taken;
        end
    end

endmodule

`default_nettype wire

/* execute/ex_branch_unit.sv */
// Branch compare and next-PC logic, fed by the held stage-1 values and read by the top level
`include "ex_macros.svh"
`default_nettype none

module ex_branch_unit (
    input  ex_ctrl_pkg::ex_kind_e  kind,
    input  logic [2:0]             funct3,
    input  logic [`EX_XLEN-1:0]    pc,
    input  logic [`EX_XLEN-1:0]    rs1_value,
    input  logic [`EX_XLEN-1:0]    rs2_value,
    input  logic [`EX_XLEN-1:0]    imm,
    output logic [`EX_XLEN-1:0]    next_pc,
    output logic                   branch_taken,
    output logic [`EX_XLEN-1:0]    link
);
    import ex_ctrl_pkg::*;

    logic                 cond;         // Branch condition from funct3
    logic [`EX_XLEN-1:0]  pc_target;
    logic [`EX_XLEN-1:0]  reg_target;

    // BEQ, BNE, BLT, BGE, BLTU, BGEU by funct3
    always_comb
    begin
        case (funct3)
            3'b000:  cond = rs1_value == rs2_value;
            3'b001:  cond = rs1_value != rs2_value;
            3'b100:  cond = $signed(rs1_value) <  $signed(rs2_value);
            3'b101:  cond = $signed(rs1_value) >= $signed(rs2_value);
            3'b110:  cond = rs1_value <  rs2_value;
            3'b111:  cond = rs1_value >= rs2_value;
            default: cond = 1'b0;   // 010 and 011 are not branches
        endcase
    end

    assign link       = pc + `EX_XLEN'd4;
    assign pc_target  = pc + imm;
    // JALR drops bit 0 of the sum
    assign reg_target = (rs1_value + imm) & ~`EX_XLEN'd1;

    always_comb
    begin
        case (kind)
            KIND_BRANCH: branch_taken = cond;
            KIND_JAL:    branch_taken = 1'b1;
            KIND_JALR:   branch_taken = 1'b1;
            default:     branch_taken = 1'b0;
        endcase
    end

    assign next_pc = (kind == KIND_JALR) ? reg_target :
                     branch_taken        ? pc_target  : link;

endmodule

`default_nettype wire

/* execute/ex_operand_stage.sv */
// First execute pipeline register, holding one decoded instruction and feeding its operands to the ALU
`include "ex_macros.svh"
`default_nettype none

module ex_operand_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  ex_ctrl_pkg::alu_op_e    alu_op,
    input  ex_ctrl_pkg::op_a_src_e  a_src,
    input  ex_ctrl_pkg::op_b_src_e  b_src,
    input  ex_ctrl_pkg::ex_kind_e   kind,
    input  logic [2:0]              funct3,
    input  logic [`EX_REG_AW-1:0]   rd,
    input  logic                    reg_write,
    input  logic [`EX_XLEN-1:0]     imm,
    input  logic [`EX_XLEN-1:0]     pc,
    input  logic [`EX_XLEN-1:0]     rs1_value,
    input  logic [`EX_XLEN-1:0]     rs2_value,
    output logic                    s1_valid,
    input  logic                    s1_ready,
    output ex_ctrl_pkg::ex_kind_e   s1_kind,
    output logic [2:0]              s1_funct3,
    output logic [`EX_REG_AW-1:0]   s1_rd,
    output logic                    s1_reg_write,
    output logic [`EX_XLEN-1:0]     s1_pc,
    output logic [`EX_XLEN-1:0]     s1_imm,
    output logic [`EX_XLEN-1:0]     s1_rs1_value,
    output logic [`EX_XLEN-1:0]     s1_rs2_value,
    output logic [`EX_XLEN-1:0]     alu_result
);
    import ex_ctrl_pkg::*;

    alu_op_e              s1_alu_op;    // Control that only this stage needs
    op_a_src_e            s1_a_src;
    op_b_src_e            s1_b_src;
    logic [`EX_XLEN-1:0]  op_a;
    logic [`EX_XLEN-1:0]  op_b;

    // Takes a new word when empty or when the held one leaves this cycle
    assign in_ready = !s1_valid || s1_ready;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            s1_valid <= 1'b0;
        else if (in_ready)
            s1_valid <= in_valid;   // Drains to empty when nothing new arrives
    end

    // Payload moves only on a real transfer
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            s1_alu_op    <= alu_op;
            s1_a_src     <= a_src;
            s1_b_src     <= b_src;
            s1_kind      <= kind;
            s1_funct3    <= funct3;
            s1_rd        <= rd;
            s1_reg_write <= reg_write;
            s1_pc        <= pc;
            s1_imm       <= imm;
            s1_rs1_value <= rs1_value;
            s1_rs2_value <= rs2_value;
        end
    end

    // Operand A is rs1, the PC, or zero for LUI
    always_comb
    begin
        case (s1_a_src)
            A_RS1:   op_a = s1_rs1_value;
            A_PC:    op_a = s1_pc;
            default: op_a = '0;
        endcase
    end

    assign op_b = (s1_b_src == B_IMM) ? s1_imm : s1_rs2_value;

    // Result is ready in the same cycle as s1_valid
    ex_alu ex_alu_inst (
        .op (s1_alu_op),
        .a  (op_a),
        .b  (op_b),
        .y  (alu_result)
    );

endmodule

`default_nettype wire

/* execute/ex_decoder.sv */
// Combinational RV32I decoder turning one instruction word into execute-stage control and immediate
`include "ex_macros.svh"
`default_nettype none

module ex_decoder (
    input  rv_isa_pkg::rv_instr_u   instr,
    output ex_ctrl_pkg::alu_op_e    alu_op,
    output ex_ctrl_pkg::op_a_src_e  a_src,
    output ex_ctrl_pkg::op_b_src_e  b_src,
    output ex_ctrl_pkg::ex_kind_e   kind,
    output logic [2:0]              funct3,
    output logic [`EX_REG_AW-1:0]   rd,
    output logic                    reg_write,
    output logic [`EX_XLEN-1:0]     imm
);
    import rv_isa_pkg::*;
    import ex_ctrl_pkg::*;

    logic [31:0]          word;        // Flat copy for the scattered immediate bits
    logic [`EX_XLEN-1:0]  imm_i;
    logic [`EX_XLEN-1:0]  imm_s;
    logic [`EX_XLEN-1:0]  imm_b;
    logic [`EX_XLEN-1:0]  imm_u;
    logic [`EX_XLEN-1:0]  imm_j;
    logic                 writes_rd;   // Opcode class writes a register at all

    // funct3 plus bit 30 pick the ALU operation
    // SUB only exists in register form while SRA exists in both
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic bit30,
                                               input logic is_reg);
        alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && bit30) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = bit30 ? ALU_SRA : ALU_SRL;   // SRAI has imm[10] in this spot
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign word   = instr;
    assign funct3 = instr.r.funct3;
    assign rd     = instr.r.rd;

    // Every immediate except U is sign-extended from bit 31
    assign imm_i = {{20{word[31]}}, instr.i.imm};
    assign imm_s = {{20{word[31]}}, instr.r.funct7, instr.r.rd};
    assign imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

    always_comb
    begin
        // Defaults describe the no-op that an unknown opcode becomes
        alu_op    = ALU_ADD;
        a_src     = A_RS1;
        b_src     = B_IMM;
        kind      = KIND_SEQ;
        imm       = imm_i;
        writes_rd = 1'b0;
        case (instr.r.opcode)
            OPC_OP:
            begin
                alu_op    = alu_from_funct(instr.r.funct3, instr.r.funct7[5], 1'b1);
                b_src     = B_RS2;
                writes_rd = 1'b1;
            end
            OPC_OP_IMM:
            begin
                alu_op    = alu_from_funct(instr.i.funct3, instr.r.funct7[5], 1'b0);
                writes_rd = 1'b1;
            end
            OPC_LUI:
            begin
                alu_op    = ALU_PASS_B;    // Upper immediate goes straight to rd
                a_src     = A_ZERO;
                imm       = imm_u;
                writes_rd = 1'b1;
            end
            OPC_AUIPC:
            begin
                a_src     = A_PC;
                imm       = imm_u;
                writes_rd = 1'b1;
            end
            OPC_JAL:
            begin
                a_src     = A_PC;          // The branch unit forms the target and rd gets the link
                kind      = KIND_JAL;
                imm       = imm_j;
                writes_rd = 1'b1;
            end
            OPC_JALR:
            begin
                kind      = KIND_JALR;
                writes_rd = 1'b1;
            end
            OPC_BRANCH:
            begin
                alu_op = ALU_SUB;          // Compare happens in the branch unit
                b_src  = B_RS2;
                kind   = KIND_BRANCH;
                imm    = imm_b;
            end
            OPC_LOAD:   writes_rd = 1'b1;  // Result is the effective address
            OPC_STORE:  imm = imm_s;       // Stores form the address and write nothing back
            default:    writes_rd = 1'b0;
        endcase
    end

    // A write to the hardwired x0 is dropped here
    assign reg_write = writes_rd && (instr.r.rd != '0);

endmodule

`default_nettype wire

/* execute/ex_alu.sv */
// Combinational RV32I ALU, driven from the operand stage with a selected op and two operands
`include "ex_macros.svh"
`default_nettype none

module ex_alu (
    input  ex_ctrl_pkg::alu_op_e  op,
    input  logic [`EX_XLEN-1:0]   a,
    input  logic [`EX_XLEN-1:0]   b,
    output logic [`EX_XLEN-1:0]   y
);
    import ex_ctrl_pkg::*;

    logic [4:0] shamt;     // RV32I shifts look at the low 5 bits only
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb
    begin
        case (op)
            ALU_ADD:    y = a + b;
            ALU_SUB:    y = a - b;
            ALU_SLL:    y = a << shamt;
            ALU_SLT:    y = {{(`EX_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   y = {{(`EX_XLEN-1){1'b0}}, lt_u};
            ALU_XOR:    y = a ^ b;
            ALU_SRL:    y = a >> shamt;
            ALU_SRA:    y = $signed(a) >>> shamt;   // Sign bit fills in from the left
            ALU_OR:     y = a | b;
            ALU_AND:    y = a & b;
            ALU_PASS_B: y = b;
            default:    y = '0;                     // Unused codes give zero
        endcase
    end

endmodule

`default_nettype wire

/* common/ex_ctrl_pkg.sv */
// Internal control types of the execute stage, shared by decoder, operand stage, ALU and branch unit
`default_nettype none

package ex_ctrl_pkg;

    // ALU operation, eleven codes in a 4-bit field
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,        // Signed less-than
        ALU_SLTU,       // Unsigned less-than
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // Result is operand B untouched
    } alu_op_e;

    // Where operand A comes from
    typedef enum logic [1:0] {
        A_RS1,
        A_PC,           // AUIPC and the jumps
        A_ZERO          // LUI
    } op_a_src_e;

    // Where operand B comes from
    typedef enum logic {
        B_RS2,
        B_IMM
    } op_b_src_e;

    // Next-PC behavior of the instruction
    typedef enum logic [1:0] {
        KIND_SEQ,       // Falls through to pc+4
        KIND_BRANCH,    // Conditional, target pc+imm
        KIND_JAL,       // Unconditional, target pc+imm
        KIND_JALR       // Unconditional, target rs1+imm with bit 0 cleared
    } ex_kind_e;

endpackage

`default_nettype wire

/* common/rv_isa_pkg.sv */
// RV32I instruction encoding types, imported by the decoder and sized through ex_macros.svh
`include "ex_macros.svh"
`default_nettype none

package rv_isa_pkg;

    // Major opcodes handled by the execute stage
    // Anything else decodes as a no-op
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,    // Register-register ALU
        OPC_OP_IMM = 7'b0010011,    // Register-immediate ALU
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } rv_opcode_e;

    // Register-register view, also used for the S and B immediate pieces
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`EX_REG_AW-1:0] rs2;
        logic [`EX_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`EX_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } rv_r_fields_t;

    // Immediate view with the 12-bit I-format field on top
    typedef struct packed {
        logic [11:0]           imm;
        logic [`EX_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`EX_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } rv_i_fields_t;

    // One 32-bit word seen either way
    typedef union packed {
        rv_r_fields_t r;
        rv_i_fields_t i;
    } rv_instr_u;

endpackage

`default_nettype wire

/* common/ex_macros.svh */
// Width macros shared by the execute-stage packages and RTL, pulled in with `include
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Data path width of RV32I, also the width of every address
`define EX_XLEN 32

// Register specifier width, enough for x0 to x31
`define EX_REG_AW 5

`endif
